// File: design/lockstep_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Widths, vector types and encodings shared by the lockstep checker RTL.
// Instruction word is a 4-bit opcode over a 12-bit immediate.
// The compared output vector is ordered pc, store, store address, data.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package lockstep_pkg;

  // Datapath widths
  localparam int unsigned DataW  = 32;
  localparam int unsigned InstrW = 16;
  localparam int unsigned AddrW  = 12;

  typedef logic [DataW-1:0]  data_t;
  typedef logic [InstrW-1:0] instr_t;
  typedef logic [AddrW-1:0]  addr_t;

  // Opcode field sits in the top nibble of the instruction
  typedef enum logic [3:0] {
    OpNop     = 4'h0,
    OpAdd     = 4'h1,
    OpXor     = 4'h2,
    OpLoadImm = 4'h3,
    OpStore   = 4'h4,
    OpJump    = 4'h5,
    OpHalt    = 4'h6
  } op_e;

  typedef enum logic [0:0] {
    CoreRun  = 1'b0,
    CoreHalt = 1'b1
  } core_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Packed lane widths
  ////////////////////////////////////////////////////////////////////////////

  // pc, store strobe, store address, store data
  localparam int unsigned CoreOutW = AddrW + 1 + AddrW + DataW;

  // Instruction valid and instruction word
  localparam int unsigned CoreInW = 1 + InstrW;

endpackage

`default_nettype wire

// File: design/acc_core.sv
////////////////////////////////////////////////////////////////////////////
// Small accumulator core standing in for the full processor.
// All outputs are registered. Store address and data hold between stores.
// Illegal opcodes raise a one-cycle minor alert and otherwise act as a NOP.
// Once halted the core stays halted until reset.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module acc_core (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_valid_i,
  input  lockstep_pkg::instr_t  instr_rdata_i,
  output lockstep_pkg::addr_t   pc_o,
  output logic                  store_o,
  output lockstep_pkg::addr_t   store_addr_o,
  output lockstep_pkg::data_t   store_data_o,
  output logic                  alert_minor_o
);

  import lockstep_pkg::*;

  core_state_e state_q, state_d;
  addr_t       pc_q, pc_d;
  data_t       acc_q, acc_d;
  logic        store_q, store_d;
  addr_t       store_addr_q, store_addr_d;
  data_t       store_data_q, store_data_d;
  logic        alert_q, alert_d;

  op_e         opcode;
  addr_t       imm;
  data_t       imm_ext;
  logic        exec;

  // Instruction fields
  assign opcode  = op_e'(instr_rdata_i[InstrW-1 -: 4]);
  assign imm     = instr_rdata_i[AddrW-1:0];
  assign imm_ext = DataW'(imm);
  assign exec    = instr_valid_i && (state_q == CoreRun);

  ////////////////////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    pc_d         = pc_q;
    acc_d        = acc_q;
    store_d      = 1'b0;
    store_addr_d = store_addr_q;
    store_data_d = store_data_q;
    alert_d      = 1'b0;

    if (exec) begin
      pc_d = pc_q + AddrW'(1);
      case (opcode)
        OpNop: ;
        OpAdd:     acc_d = acc_q + imm_ext;
        OpXor:     acc_d = acc_q ^ imm_ext;
        OpLoadImm: acc_d = imm_ext;
        OpStore: begin
          store_d      = 1'b1;
          store_addr_d = imm;
          store_data_d = acc_q;
        end
        OpJump:    pc_d = imm;
        OpHalt: begin
          // Halt does not advance pc
          pc_d    = pc_q;
          state_d = CoreHalt;
        end
        default:   alert_d = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= CoreRun;
      pc_q         <= '0;
      acc_q        <= '0;
      store_q      <= 1'b0;
      store_addr_q <= '0;
      store_data_q <= '0;
      alert_q      <= 1'b0;
    end else begin
      state_q      <= state_d;
      pc_q         <= pc_d;
      acc_q        <= acc_d;
      store_q      <= store_d;
      store_addr_q <= store_addr_d;
      store_data_q <= store_data_d;
      alert_q      <= alert_d;
    end
  end

  assign pc_o          = pc_q;
  assign store_o       = store_q;
  assign store_addr_o  = store_addr_q;
  assign store_data_o  = store_data_q;
  assign alert_minor_o = alert_q;

  // A halted core never moves its pc again
  halt_pc_stable_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == CoreHalt) |=> $stable(pc_o)
  );

endmodule

`default_nettype wire

// File: design/lockstep_rst_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Holds the shadow core in reset for LockstepOffset cycles after reset.
// Comparison is enabled one cycle after the shadow reset is released.
// LockstepOffset must be 2 or more.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lockstep_rst_ctrl #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  localparam int unsigned CntW = $clog2(LockstepOffset);

  if (LockstepOffset < 2) begin : gen_offset_check
    $error("LockstepOffset must be at least 2");
  end

  logic [CntW-1:0] cnt_q, cnt_d;
  logic            release_d;
  logic            shadow_rst_nq;
  logic            cmp_en_q;

  // Counter stops on the last offset cycle
  assign release_d = (cnt_q == CntW'(LockstepOffset - 1));
  assign cnt_d     = release_d ? cnt_q : cnt_q + CntW'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q         <= '0;
      shadow_rst_nq <= 1'b0;
      cmp_en_q      <= 1'b0;
    end else begin
      cnt_q         <= cnt_d;
      shadow_rst_nq <= release_d;
      cmp_en_q      <= shadow_rst_nq;
    end
  end

  assign shadow_rst_no = shadow_rst_nq;
  assign cmp_en_o      = cmp_en_q;

  // Comparison only runs against a shadow core that is out of reset
  cmp_after_release_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmp_en_o |-> shadow_rst_no
  );

endmodule

`default_nettype wire

// File: design/lockstep_delay_line.sv
////////////////////////////////////////////////////////////////////////////
// Shift register of Width bits and Depth stages.
// With ResetEn clear the stages are not reset and start undefined.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lockstep_delay_line #(
  parameter int unsigned Width   = 1,
  parameter int unsigned Depth   = 2,
  parameter bit          ResetEn = 1'b1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  if (Depth < 1) begin : gen_depth_check
    $error("Depth must be at least 1");
  end

  logic [Depth-1:0][Width-1:0] stage_q;
  logic [Depth-1:0][Width-1:0] stage_d;

  // Stage 0 takes the input, the rest shift along
  always_comb begin
    stage_d[0] = d_i;
    for (int unsigned i = 1; i < Depth; i++) begin
      stage_d[i] = stage_q[i-1];
    end
  end

  if (ResetEn) begin : gen_rst
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        stage_q <= '0;
      end else begin
        stage_q <= stage_d;
      end
    end
  end else begin : gen_no_rst
    always_ff @(posedge clk_i) begin
      stage_q <= stage_d;
    end
  end

  assign q_o = stage_q[Depth-1];

endmodule

`default_nettype wire

// File: design/lockstep_compare.sv
////////////////////////////////////////////////////////////////////////////
// Registers the shadow outputs and compares them with the delayed main
// outputs. The major alert is a combinational, non-sticky level.
// The shadow minor alert is passed straight out.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lockstep_compare (
  input  logic                              clk_i,
  input  logic                              cmp_en_i,
  input  logic [lockstep_pkg::CoreOutW-1:0] shadow_out_i,
  input  logic [lockstep_pkg::CoreOutW-1:0] main_out_i,
  input  logic                              shadow_alert_minor_i,
  output logic                              alert_major_o,
  output logic                              alert_minor_o
);

  import lockstep_pkg::*;

  logic [CoreOutW-1:0] shadow_out_q;
  logic                mismatch;

  // One register stage lines the shadow up with the main delay line
  always_ff @(posedge clk_i) begin
    shadow_out_q <= shadow_out_i;
  end

  assign mismatch = (shadow_out_q != main_out_i);

  ////////////////////////////////////////////////////////////////////////////
  // Alerts
  ////////////////////////////////////////////////////////////////////////////

  assign alert_major_o = cmp_en_i & mismatch;
  assign alert_minor_o = shadow_alert_minor_i;

  // No major alert before comparison is enabled
  major_masked_a : assert property (
    @(posedge clk_i)
    !cmp_en_i |-> !alert_major_o
  );

endmodule

`default_nettype wire

// File: design/lockstep_top.sv
////////////////////////////////////////////////////////////////////////////
// Lockstep checker around a shadow copy of the accumulator core.
// Shadow inputs lag the main core by LockstepOffset cycles and main
// outputs are compared LockstepOffset+1 cycles after they appear.
// The main core outputs must be registered, as in acc_core.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lockstep_top #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 instr_valid_i,
  input  lockstep_pkg::instr_t instr_rdata_i,
  input  lockstep_pkg::addr_t  core_pc_i,
  input  logic                 core_store_i,
  input  lockstep_pkg::addr_t  core_store_addr_i,
  input  lockstep_pkg::data_t  core_store_data_i,
  output logic                 alert_major_o,
  output logic                 alert_minor_o
);

  import lockstep_pkg::*;

  // Extra stage matches the shadow output register
  localparam int unsigned OutDepth = LockstepOffset + 1;

  logic                shadow_rst_n;
  logic                cmp_en;

  logic [CoreInW-1:0]  main_in;
  logic [CoreInW-1:0]  shadow_in;
  logic [CoreOutW-1:0] main_out;
  logic [CoreOutW-1:0] main_out_dly;
  logic [CoreOutW-1:0] shadow_out;

  logic                shadow_instr_valid;
  instr_t              shadow_instr;
  addr_t               shadow_pc;
  logic                shadow_store;
  addr_t               shadow_store_addr;
  data_t               shadow_store_data;
  logic                shadow_alert_minor;

  lockstep_rst_ctrl #(
    .LockstepOffset(LockstepOffset)
  ) u_rst_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .shadow_rst_no(shadow_rst_n),
    .cmp_en_o     (cmp_en)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Delay lanes
  ////////////////////////////////////////////////////////////////////////////

  assign main_in = {instr_valid_i, instr_rdata_i};
  assign {shadow_instr_valid, shadow_instr} = shadow_in;

  lockstep_delay_line #(
    .Width  (CoreInW),
    .Depth  (LockstepOffset),
    .ResetEn(1'b1)
  ) u_in_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (main_in),
    .q_o   (shadow_in)
  );

  assign main_out = {core_pc_i, core_store_i, core_store_addr_i, core_store_data_i};

  // Masked by the compare enable until it is filled
  lockstep_delay_line #(
    .Width  (CoreOutW),
    .Depth  (OutDepth),
    .ResetEn(1'b0)
  ) u_out_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .d_i   (main_out),
    .q_o   (main_out_dly)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shadow core and comparison
  ////////////////////////////////////////////////////////////////////////////

  acc_core u_shadow_core (
    .clk_i        (clk_i),
    .rst_ni       (shadow_rst_n),
    .instr_valid_i(shadow_instr_valid),
    .instr_rdata_i(shadow_instr),
    .pc_o         (shadow_pc),
    .store_o      (shadow_store),
    .store_addr_o (shadow_store_addr),
    .store_data_o (shadow_store_data),
    .alert_minor_o(shadow_alert_minor)
  );

  assign shadow_out = {shadow_pc, shadow_store, shadow_store_addr, shadow_store_data};

  lockstep_compare u_compare (
    .clk_i               (clk_i),
    .cmp_en_i            (cmp_en),
    .shadow_out_i        (shadow_out),
    .main_out_i          (main_out_dly),
    .shadow_alert_minor_i(shadow_alert_minor),
    .alert_major_o       (alert_major_o),
    .alert_minor_o       (alert_minor_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_core_model.svh
////////////////////////////////////////////////////////////////////////////
// Reference model for one rising edge of the accumulator core.
// Include inside a module body that imports lockstep_pkg.
// Any opcode outside op_e is illegal and raises the alert flag.
////////////////////////////////////////////////////////////////////////////

`ifndef TB_CORE_MODEL_SVH
`define TB_CORE_MODEL_SVH

// Core state after one edge with the given instruction strobe and word
function automatic void core_step(
  input  logic        valid,
  input  instr_t      instr,
  input  core_state_e state,
  input  addr_t       pc,
  input  data_t       acc,
  input  addr_t       saddr,
  input  data_t       sdata,
  output core_state_e state_n,
  output addr_t       pc_n,
  output data_t       acc_n,
  output logic        store_n,
  output addr_t       saddr_n,
  output data_t       sdata_n,
  output logic        alert_n
);
  logic [3:0] op;
  addr_t      imm;
  op      = instr[15:12];
  imm     = instr[11:0];
  state_n = state;
  pc_n    = pc;
  acc_n   = acc;
  store_n = 1'b0;
  saddr_n = saddr;
  sdata_n = sdata;
  alert_n = 1'b0;
  // A halted core ignores all instructions until reset
  if (!valid || state != CoreRun) return;

  // Program counter
  if (op == OpJump) pc_n = imm;
  else if (op == OpHalt) state_n = CoreHalt;
  else pc_n = pc + 12'd1;

  // Accumulator, store port and alert
  case (op)
    OpAdd:     acc_n = acc + data_t'(imm);
    OpXor:     acc_n = acc ^ data_t'(imm);
    OpLoadImm: acc_n = data_t'(imm);
    OpStore: begin
      store_n = 1'b1;
      saddr_n = imm;
      sdata_n = acc;
    end
    OpNop, OpJump, OpHalt: ;
    default:   alert_n = 1'b1;
  endcase
endfunction

`endif

// File: bench/tb_lockstep.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for lockstep_top. It plays the main core with a reference
// model and predicts both alerts from the fault and alert history.
// Faults are injected on the store data port only.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_lockstep;

  import lockstep_pkg::*;

  `include "tb_core_model.svh"

  localparam int unsigned Offset  = 2;
  localparam int unsigned Timeout = 40;

  logic        clk_i  = 1'b1;
  logic        rst_ni = 1'b1;
  logic        instr_valid;
  instr_t      instr_rdata;
  addr_t       core_pc;
  logic        core_store;
  addr_t       core_store_addr;
  data_t       core_store_data;
  logic        alert_major;
  logic        alert_minor;

  // Main core model
  core_state_e m_state;
  addr_t       m_pc;
  data_t       m_acc;
  logic        m_store;
  addr_t       m_saddr;
  data_t       m_sdata;

  // Expected alert history with the newest entry at index 0
  logic [Offset:0] fault_hist;
  logic [Offset:0] minor_hist;
  logic            fault_now = 1'b0;
  int unsigned     since_rel = 0;
  int unsigned     major_cnt = 0;
  int unsigned     minor_cnt = 0;
  integer          seed      = 32'hf22e_da26;

  lockstep_top #(
    .LockstepOffset(Offset)
  ) dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid),
    .instr_rdata_i    (instr_rdata),
    .core_pc_i        (core_pc),
    .core_store_i     (core_store),
    .core_store_addr_i(core_store_addr),
    .core_store_data_i(core_store_data),
    .alert_major_o    (alert_major),
    .alert_minor_o    (alert_minor)
  );

  always #2 clk_i = ~clk_i;

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main core model and alert prediction
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : model_step
    core_state_e state_n;
    addr_t       pc_n;
    data_t       acc_n;
    logic        store_n;
    addr_t       saddr_n;
    data_t       sdata_n;
    logic        alert_n;
    if (!rst_ni) begin
      m_state    <= CoreRun;
      m_pc       <= '0;
      m_acc      <= '0;
      m_store    <= 1'b0;
      m_saddr    <= '0;
      m_sdata    <= '0;
      fault_hist <= '0;
      minor_hist <= '0;
      since_rel  <= 0;
    end else begin
      core_step(instr_valid, instr_rdata, m_state, m_pc, m_acc, m_saddr, m_sdata,
                state_n, pc_n, acc_n, store_n, saddr_n, sdata_n, alert_n);
      m_state    <= state_n;
      m_pc       <= pc_n;
      m_acc      <= acc_n;
      m_store    <= store_n;
      m_saddr    <= saddr_n;
      m_sdata    <= sdata_n;
      fault_hist <= {fault_hist[Offset-1:0], fault_now};
      minor_hist <= {minor_hist[Offset-1:0], alert_n};
      if (since_rel < 1000) since_rel <= since_rel + 1;
    end
  end

  // Alerts as they stood in the cycle that just ended
  always @(posedge clk_i) begin : compare_alerts
    logic exp_major;
    logic exp_minor;
    exp_major = rst_ni && (since_rel > Offset) && fault_hist[Offset];
    exp_minor = rst_ni && minor_hist[Offset];
    check("alert_major", 64'(exp_major), 64'(alert_major));
    check("alert_minor", 64'(exp_minor), 64'(alert_minor));
    if (alert_major) major_cnt++;
    if (alert_minor) minor_cnt++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input logic valid, input instr_t instr, input data_t mask);
    @(negedge clk_i);
    instr_valid     = valid;
    instr_rdata     = instr;
    fault_now       = |mask;
    core_pc         = m_pc;
    core_store      = m_store;
    core_store_addr = m_saddr;
    core_store_data = m_sdata ^ mask;
  endtask

  function automatic instr_t rand_legal_instr();
    logic [31:0] r;
    logic [3:0]  op;
    r  = $random(seed);
    op = 4'(r[31:16] % 16'd6);
    return {op, r[11:0]};
  endfunction

  task automatic run_random(input int unsigned cycles);
    logic [31:0] r;
    repeat (cycles) begin
      r = $random(seed);
      drive_cycle(r[1:0] != 2'b00, rand_legal_instr(), '0);
    end
  endtask

  task automatic wait_compare_enable();
    int unsigned n;
    n = 0;
    while (since_rel <= Offset && n < Timeout) begin
      drive_cycle(1'b0, '0, '0);
      n++;
    end
    if (since_rel <= Offset) timeout_fail("compare enable after reset");
  endtask

  task automatic wait_alert(input bit major, input int unsigned start);
    int unsigned n;
    n = 0;
    while ((major ? major_cnt : minor_cnt) == start && n < Timeout) begin
      drive_cycle(1'b0, '0, '0);
      n++;
    end
    if ((major ? major_cnt : minor_cnt) == start) begin
      timeout_fail(major ? "major alert" : "minor alert");
    end
  endtask

  initial begin : stimulus
    int unsigned start_major;
    int unsigned start_minor;
    addr_t       pc_before;
    data_t       mask;
    logic [31:0] r;
    instr_valid     = 1'b0;
    instr_rdata     = '0;
    core_pc         = '0;
    core_store      = 1'b0;
    core_store_addr = '0;
    core_store_data = '0;

    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (10) drive_cycle(1'b0, '0, '0);
    rst_ni = 1'b1;

    // Clean run
    wait_compare_enable();
    start_major = major_cnt;
    run_random(300);
    repeat (Offset + 2) drive_cycle(1'b0, '0, '0);
    check("clean_run", 64'(start_major), 64'(major_cnt));

    // Single cycle fault on one store data bit
    r    = $random(seed);
    mask = data_t'(1) << r[4:0];
    drive_cycle(1'b0, '0, mask);
    wait_alert(1'b1, start_major);
    repeat (Offset + 2) drive_cycle(1'b0, '0, '0);
    check("fault_pulse", 64'(start_major + 1), 64'(major_cnt));

    // Illegal opcode
    start_major = major_cnt;
    start_minor = minor_cnt;
    pc_before   = m_pc;
    r           = $random(seed);
    drive_cycle(1'b1, {4'h7 + 4'(r[15:0] % 16'd9), r[11:0]}, '0);
    drive_cycle(1'b0, '0, '0);
    check("illegal_pc", 64'(pc_before + 12'd1), 64'(m_pc));
    wait_alert(1'b0, start_minor);
    repeat (Offset + 2) drive_cycle(1'b0, '0, '0);
    check("illegal_minor", 64'(start_minor + 1), 64'(minor_cnt));
    check("illegal_major", 64'(start_major), 64'(major_cnt));

    // Halt, then further instructions are ignored
    drive_cycle(1'b1, {4'(OpHalt), 12'h0a5}, '0);
    drive_cycle(1'b0, '0, '0);
    pc_before = m_pc;
    check("halt_state", 64'(CoreHalt), 64'(m_state));
    run_random(50);
    check("halt_pc", 64'(pc_before), 64'(m_pc));
    check("halt_major", 64'(start_major), 64'(major_cnt));

    // Reset in the middle of a fault
    mask = 32'h0000_0100;
    repeat (6) drive_cycle(1'b0, '0, mask);
    check("fault_before_reset", 64'd1, 64'(major_cnt != start_major));
    rst_ni = 1'b0;
    repeat (5) drive_cycle(1'b1, rand_legal_instr(), mask);
    drive_cycle(1'b0, '0, '0);
    rst_ni = 1'b1;
    repeat (Offset + 1) begin
      drive_cycle(1'b0, '0, '0);
      check("release_major", 64'd0, 64'(alert_major));
      check("release_minor", 64'd0, 64'(alert_minor));
    end
    wait_compare_enable();
    start_major = major_cnt;
    start_minor = minor_cnt;
    run_random(100);
    repeat (Offset + 2) drive_cycle(1'b0, '0, '0);
    check("rerun_major", 64'(start_major), 64'(major_cnt));
    check("rerun_minor", 64'(start_minor), 64'(minor_cnt));

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+bench
design/lockstep_pkg.sv
design/acc_core.sv
design/lockstep_rst_ctrl.sv
design/lockstep_delay_line.sv
design/lockstep_compare.sv
design/lockstep_top.sv
bench/tb_lockstep.sv

// File: run.sh
#!/bin/sh
# Compile and run the lockstep testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_lockstep -f build.f -o sim_lockstep

out=$(./obj_dir/sim_lockstep) || true
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
